//--- src/stlb_pkg.sv
// shared TLB package
// Sv32 address and PTE widths
// packed PTE, tag, lookup request and TLB update types

package stlb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sv32 geometry
  //////////////////////////////////////////////////////////////////////
  localparam int unsigned VLEN          = 32;
  localparam int unsigned PAGE_OFFSET_W = 12;
  localparam int unsigned VPN_LEVEL_W   = 10;
  localparam int unsigned PT_LEVELS     = 2;
  localparam int unsigned ASID_W        = 9;
  localparam int unsigned PTE_W         = 32;

  // level 1 is the upper field
  typedef logic [PT_LEVELS-1:0][VPN_LEVEL_W-1:0] vpn_t;

  // Sv32 page-table entry
  typedef struct packed {
    logic [PTE_W-11:0] ppn;  // 22 bits
    logic [1:0]        rsw;
    logic              d;
    logic              a;
    logic              g;    // global, asid ignored
    logic              u;
    logic              x;
    logic              w;
    logic              r;
    logic              v;
  } pte_t;

  //////////////////////////////////////////////////////////////////////
  // stored and transported entries
  //////////////////////////////////////////////////////////////////////

  // per-way tag, sits beside the pte
  typedef struct packed {
    logic [ASID_W-1:0] asid;
    vpn_t              vpn;
    logic              is_4m;  // superpage
  } tag_t;

  // registered lookup, decode to execute
  typedef struct packed {
    logic              valid;
    logic              is_itlb;
    vpn_t              vpn;
    logic [ASID_W-1:0] asid;
  } lookup_req_t;

  // walker refill and ITLB/DTLB update
  typedef struct packed {
    logic              valid;
    vpn_t              vpn;
    logic              is_4m;
    logic [ASID_W-1:0] asid;
    pte_t              content;
  } tlb_update_t;

endpackage

//--- src/stlb_way_ram.sv
// single-port synchronous RAM for one TLB way
// payload type set per instance (tag or pte)
// write wins over read, read data one cycle later

`timescale 1ns/10ps

module stlb_way_ram #(
  parameter int unsigned Depth   = 64,
  parameter type         entry_t = logic
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  entry_t mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];  // holds when idle
      end
    end
  end

endmodule

//--- src/stlb_lookup_req.sv
// decode stage of the shared TLB
// picks the ITLB or DTLB miss, drives the set read
// registers the lookup request and the selected vaddr

`timescale 1ns/10ps

module stlb_lookup_req #(
  parameter int unsigned Depth = 64
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            s_st_enbl_i,
  input  logic                            s_ld_st_enbl_i,
  input  logic [stlb_pkg::ASID_W-1:0]     itlb_asid_i,
  input  logic [stlb_pkg::ASID_W-1:0]     dtlb_asid_i,
  input  logic                            itlb_access_i,
  input  logic                            itlb_hit_i,
  input  logic [stlb_pkg::VLEN-1:0]       itlb_vaddr_i,
  input  logic                            dtlb_access_i,
  input  logic                            dtlb_hit_i,
  input  logic [stlb_pkg::VLEN-1:0]       dtlb_vaddr_i,
  input  logic                            shared_tlb_miss_i,
  output logic                            rd_en_o,
  output logic [$clog2(Depth)-1:0]        rd_idx_o,
  output stlb_pkg::lookup_req_t           req_o,
  output logic                            itlb_miss_o,
  output logic                            dtlb_miss_o,
  output logic                            shared_tlb_access_o,
  output logic [stlb_pkg::VLEN-1:0]       shared_tlb_vaddr_o,
  output logic                            itlb_req_o
);

  localparam int unsigned IdxW = $clog2(Depth);

  logic                        itlb_sel;
  logic                        dtlb_sel;
  logic [stlb_pkg::VLEN-1:0]   sel_vaddr;
  logic [stlb_pkg::ASID_W-1:0] sel_asid;

  logic                        valid_q;
  logic                        is_itlb_q;
  stlb_pkg::vpn_t              vpn_q;
  logic [stlb_pkg::ASID_W-1:0] asid_q;
  logic [stlb_pkg::VLEN-1:0]   vaddr_q;

  // an ITLB miss only counts while the DTLB is idle, so a tie goes to the DTLB
  assign itlb_sel = s_st_enbl_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
  assign dtlb_sel = s_ld_st_enbl_i & dtlb_access_i & ~dtlb_hit_i;

  assign sel_vaddr = itlb_sel ? itlb_vaddr_i : dtlb_vaddr_i;
  assign sel_asid  = itlb_sel ? itlb_asid_i : dtlb_asid_i;

  assign rd_en_o  = itlb_sel | dtlb_sel;
  assign rd_idx_o = sel_vaddr[stlb_pkg::PAGE_OFFSET_W +: IdxW];  // low vpn bits

  // perf counters follow the walker for the served side
  assign itlb_miss_o = itlb_sel & shared_tlb_miss_i;
  assign dtlb_miss_o = dtlb_sel & shared_tlb_miss_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      is_itlb_q <= 1'b0;
    end else begin
      valid_q   <= rd_en_o;
      is_itlb_q <= itlb_sel;
    end
  end

  // request payload, held between misses
  always_ff @(posedge clk_i) begin
    if (rd_en_o) begin
      vpn_q   <= sel_vaddr[stlb_pkg::VLEN-1:stlb_pkg::PAGE_OFFSET_W];
      asid_q  <= sel_asid;
      vaddr_q <= sel_vaddr;
    end
  end

  assign req_o = '{valid: valid_q, is_itlb: is_itlb_q, vpn: vpn_q, asid: asid_q};

  assign shared_tlb_access_o = valid_q;
  assign shared_tlb_vaddr_o  = vaddr_q;
  assign itlb_req_o          = is_itlb_q;

endmodule

//--- src/stlb_refill_ctrl.sv
// refill and flush control of the shared TLB
// valid-bit array, flush, victim way (invalid first, else LFSR)
// per-way write enables, RAM address mux, registered read-set valids

`timescale 1ns/10ps

module stlb_refill_ctrl #(
  parameter int unsigned Ways  = 2,
  parameter int unsigned Depth = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     rd_en_i,
  input  logic [$clog2(Depth)-1:0] rd_idx_i,
  input  stlb_pkg::tlb_update_t    refill_i,
  output logic [Ways-1:0]          way_we_o,
  output logic [$clog2(Depth)-1:0] ram_addr_o,
  output logic [Ways-1:0]          valid_o
);

  localparam int unsigned IdxW     = $clog2(Depth);
  localparam int unsigned WayW     = $clog2(Ways);
  localparam logic [7:0]  LfsrTaps = 8'hB8;  // x^8+x^6+x^5+x^4+1
  localparam logic [7:0]  LfsrSeed = 8'h5A;

  logic [Depth-1:0][Ways-1:0]        valid_q;
  logic [Ways-1:0]                   rd_valid_q;
  logic [$bits(stlb_pkg::vpn_t)-1:0] refill_vpn;
  logic [IdxW-1:0]                   wr_idx;
  logic [Ways-1:0]                   set_valid;
  logic                              all_valid;
  logic                              wr_en;
  logic                              lfsr_en;
  logic [7:0]                        lfsr_q;
  logic [WayW-1:0]                   inv_way;
  logic [WayW-1:0]                   rnd_way;
  logic [WayW-1:0]                   repl_way;

  //////////////////////////////////////////////////////////////////////
  // victim selection
  //////////////////////////////////////////////////////////////////////
  assign refill_vpn = refill_i.vpn;
  assign wr_idx     = refill_vpn[IdxW-1:0];
  assign set_valid  = valid_q[wr_idx];
  assign all_valid  = &set_valid;

  // lowest invalid way
  always_comb begin
    inv_way = '0;
    for (int i = Ways - 1; i >= 0; i--) begin
      if (!set_valid[i]) inv_way = WayW'(i);
    end
  end

  assign rnd_way  = lfsr_q[WayW-1:0];
  assign repl_way = all_valid ? rnd_way : inv_way;

  assign wr_en   = refill_i.valid & ~flush_i;  // flush drops a refill
  assign lfsr_en = wr_en & all_valid;

  always_comb begin
    way_we_o = '0;
    if (wr_en) way_we_o[repl_way] = 1'b1;
  end

  // galois LFSR, steps on refills into a full set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LfsrSeed;
    end else if (lfsr_en) begin
      lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? LfsrTaps : 8'h00);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // valid bits and read path
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end else if (wr_en) begin
        valid_q[wr_idx] <= set_valid | way_we_o;
      end
      if (rd_en_i) rd_valid_q <= valid_q[rd_idx_i];  // lines up with RAM data
    end
  end

  assign ram_addr_o = wr_en ? wr_idx : rd_idx_i;  // write takes the port
  assign valid_o    = rd_valid_q;

  a_no_rd_wr_clash : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rd_en_i && (|way_we_o)));

  // a free way is used before the LFSR picks a victim
  a_invalid_first : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_en && !all_valid) |-> !(|(way_we_o & set_valid)));

endmodule

//--- src/stlb_tag_compare.sv
// execute stage tag compare
// per-way hit from valid, asid/global, vpn levels and superpage flag

`timescale 1ns/10ps

module stlb_tag_compare #(
  parameter int unsigned Ways = 2
) (
  input  stlb_pkg::lookup_req_t req_i,
  input  stlb_pkg::tag_t        tags_i [Ways],
  input  stlb_pkg::pte_t        ptes_i [Ways],
  input  logic [Ways-1:0]       valid_i,
  output logic [Ways-1:0]       way_hit_o
);

  localparam int unsigned Lvl1 = stlb_pkg::PT_LEVELS - 1;

  for (genvar w = 0; w < Ways; w++) begin : gen_way
    logic asid_match;
    logic lvl1_match;
    logic lvl0_match;

    // global entries ignore the asid
    assign asid_match = (tags_i[w].asid == req_i.asid) || ptes_i[w].g;
    assign lvl1_match = tags_i[w].vpn[Lvl1] == req_i.vpn[Lvl1];
    assign lvl0_match = (tags_i[w].vpn[0] == req_i.vpn[0]) || tags_i[w].is_4m;  // 4M page

    assign way_hit_o[w] = req_i.valid & valid_i[w] & asid_match & lvl1_match & lvl0_match;
  end

  // two ways holding the same translation means a duplicate refill upstream
  always_comb begin
    a_single_hit : assert ($onehot0(way_hit_o))
      else $error("shared TLB multi-way hit %b", way_hit_o);
  end

endmodule

//--- src/stlb_update_route.sv
// result stage of the shared TLB
// picks the hitting way and steers the update to ITLB or DTLB

`timescale 1ns/10ps

module stlb_update_route #(
  parameter int unsigned Ways = 2
) (
  input  stlb_pkg::lookup_req_t req_i,
  input  logic [Ways-1:0]       way_hit_i,
  input  stlb_pkg::tag_t        tags_i [Ways],
  input  stlb_pkg::pte_t        ptes_i [Ways],
  output logic                  hit_o,
  output stlb_pkg::tlb_update_t itlb_update_o,
  output stlb_pkg::tlb_update_t dtlb_update_o
);

  stlb_pkg::pte_t        hit_pte;
  logic                  hit_4m;
  stlb_pkg::tlb_update_t upd;

  // and-or mux, way_hit_i is one-hot or zero
  always_comb begin
    hit_pte = '0;
    hit_4m  = 1'b0;
    for (int w = 0; w < Ways; w++) begin
      if (way_hit_i[w]) begin
        hit_pte = hit_pte | ptes_i[w];
        hit_4m  = hit_4m | tags_i[w].is_4m;
      end
    end
  end

  assign hit_o = |way_hit_i;

  // vpn and asid from the lookup, not from the tag
  assign upd = '{valid: hit_o, vpn: req_i.vpn, is_4m: hit_4m,
                 asid: req_i.asid, content: hit_pte};

  assign itlb_update_o = req_i.is_itlb ? upd : '0;
  assign dtlb_update_o = req_i.is_itlb ? '0 : upd;

endmodule

//--- src/stlb_top.sv
// shared TLB top level
// decode, refill control, per-way tag and pte RAMs,
// tag compare and update routing

`timescale 1ns/10ps

module stlb_top #(
  parameter int unsigned Ways  = 2,
  parameter int unsigned Depth = 64
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        s_st_enbl_i,
  input  logic                        s_ld_st_enbl_i,
  input  logic [stlb_pkg::ASID_W-1:0] itlb_asid_i,
  input  logic [stlb_pkg::ASID_W-1:0] dtlb_asid_i,
  input  logic                        itlb_access_i,
  input  logic                        itlb_hit_i,
  input  logic [stlb_pkg::VLEN-1:0]   itlb_vaddr_i,
  input  logic                        dtlb_access_i,
  input  logic                        dtlb_hit_i,
  input  logic [stlb_pkg::VLEN-1:0]   dtlb_vaddr_i,
  input  logic                        shared_tlb_miss_i,
  input  stlb_pkg::tlb_update_t       shared_tlb_update_i,
  output stlb_pkg::tlb_update_t       itlb_update_o,
  output stlb_pkg::tlb_update_t       dtlb_update_o,
  output logic                        itlb_miss_o,
  output logic                        dtlb_miss_o,
  output logic                        shared_tlb_access_o,
  output logic                        shared_tlb_hit_o,
  output logic [stlb_pkg::VLEN-1:0]   shared_tlb_vaddr_o,
  output logic                        itlb_req_o
);

  logic                  rd_en;
  logic [$clog2(Depth)-1:0] rd_idx;
  logic [$clog2(Depth)-1:0] ram_addr;
  stlb_pkg::lookup_req_t lookup_req;
  logic [Ways-1:0]       way_we;
  logic [Ways-1:0]       rd_valid;
  logic [Ways-1:0]       way_hit;
  stlb_pkg::tag_t        tag_wdata;
  stlb_pkg::tag_t        tag_rd [Ways];
  stlb_pkg::pte_t        pte_rd [Ways];

  stlb_lookup_req #(.Depth(Depth)) u_lookup_req (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .s_st_enbl_i        (s_st_enbl_i),
    .s_ld_st_enbl_i     (s_ld_st_enbl_i),
    .itlb_asid_i        (itlb_asid_i),
    .dtlb_asid_i        (dtlb_asid_i),
    .itlb_access_i      (itlb_access_i),
    .itlb_hit_i         (itlb_hit_i),
    .itlb_vaddr_i       (itlb_vaddr_i),
    .dtlb_access_i      (dtlb_access_i),
    .dtlb_hit_i         (dtlb_hit_i),
    .dtlb_vaddr_i       (dtlb_vaddr_i),
    .shared_tlb_miss_i  (shared_tlb_miss_i),
    .rd_en_o            (rd_en),
    .rd_idx_o           (rd_idx),
    .req_o              (lookup_req),
    .itlb_miss_o        (itlb_miss_o),
    .dtlb_miss_o        (dtlb_miss_o),
    .shared_tlb_access_o(shared_tlb_access_o),
    .shared_tlb_vaddr_o (shared_tlb_vaddr_o),
    .itlb_req_o         (itlb_req_o)
  );

  stlb_refill_ctrl #(.Ways(Ways), .Depth(Depth)) u_refill_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .rd_en_i   (rd_en),
    .rd_idx_i  (rd_idx),
    .refill_i  (shared_tlb_update_i),
    .way_we_o  (way_we),
    .ram_addr_o(ram_addr),
    .valid_o   (rd_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // way arrays
  //////////////////////////////////////////////////////////////////////
  assign tag_wdata = '{asid:  shared_tlb_update_i.asid,
                       vpn:   shared_tlb_update_i.vpn,
                       is_4m: shared_tlb_update_i.is_4m};

  for (genvar w = 0; w < Ways; w++) begin : gen_way
    stlb_way_ram #(.Depth(Depth), .entry_t(stlb_pkg::tag_t)) u_tag_ram (
      .clk_i  (clk_i),
      .req_i  (way_we[w] | rd_en),
      .we_i   (way_we[w]),
      .addr_i (ram_addr),
      .wdata_i(tag_wdata),
      .rdata_o(tag_rd[w])
    );

    stlb_way_ram #(.Depth(Depth), .entry_t(stlb_pkg::pte_t)) u_pte_ram (
      .clk_i  (clk_i),
      .req_i  (way_we[w] | rd_en),
      .we_i   (way_we[w]),
      .addr_i (ram_addr),
      .wdata_i(shared_tlb_update_i.content),
      .rdata_o(pte_rd[w])
    );
  end

  stlb_tag_compare #(.Ways(Ways)) u_tag_compare (
    .req_i    (lookup_req),
    .tags_i   (tag_rd),
    .ptes_i   (pte_rd),
    .valid_i  (rd_valid),
    .way_hit_o(way_hit)
  );

  stlb_update_route #(.Ways(Ways)) u_update_route (
    .req_i        (lookup_req),
    .way_hit_i    (way_hit),
    .tags_i       (tag_rd),
    .ptes_i       (pte_rd),
    .hit_o        (shared_tlb_hit_o),
    .itlb_update_o(itlb_update_o),
    .dtlb_update_o(dtlb_update_o)
  );

endmodule

//--- test/stlb_checker.sv
// result checker for the shared TLB
// miss outputs in the request cycle, lookup results one cycle later
// counts wrong values and other failures

`timescale 1ns/10ps

module stlb_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      exp_access_i,
  input  logic                      exp_itlb_i,
  input  logic [stlb_pkg::VLEN-1:0] exp_vaddr_i,
  input  logic                      exp_imiss_i,
  input  logic                      exp_dmiss_i,
  input  logic [1:0]                exp_hit_i,  // 0 miss, 1 hit, 2 either
  input  stlb_pkg::tlb_update_t     exp_upd_i,
  input  logic                      itlb_miss_i,
  input  logic                      dtlb_miss_i,
  input  logic                      access_i,
  input  logic                      hit_i,
  input  logic                      itlb_req_i,
  input  logic [stlb_pkg::VLEN-1:0] vaddr_i,
  input  stlb_pkg::tlb_update_t     itlb_update_i,
  input  stlb_pkg::tlb_update_t     dtlb_update_i,
  output int                        value_errs_o,
  output int                        other_errs_o
);

  typedef struct packed {
    logic                      access;
    logic                      itlb;
    logic [stlb_pkg::VLEN-1:0] vaddr;
    logic [1:0]                hit;
    stlb_pkg::tlb_update_t     upd;
  } expect_t;

  expect_t cur;
  expect_t pend;  // lookup of the previous cycle
  int      value_errs  = 0;
  int      other_errs  = 0;
  int      either_cnt  = 0;
  int      either_hits = 0;

  assign cur = '{access: exp_access_i, itlb: exp_itlb_i, vaddr: exp_vaddr_i,
                 hit: exp_hit_i, upd: exp_upd_i};

  assign value_errs_o = value_errs;
  assign other_errs_o = other_errs;

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // pairs of older entries after a set overflow, one of each pair survives
  task automatic count_either(input logic hit);
    either_cnt++;
    if (hit) either_hits++;
    if (either_cnt % 2 == 0) begin
      if (either_hits != 1) begin
        other_errs++;
        $display("at %0t replacement kept %0d of 2 older entries, expected exactly 1",
                 $time, either_hits);
      end
      either_hits = 0;
    end
  endtask

  task automatic check_result();
    stlb_pkg::tlb_update_t served;
    stlb_pkg::tlb_update_t other;
    stlb_pkg::tlb_update_t want;
    string                 served_name;
    string                 other_name;
    logic                  hit_exp;
    served      = pend.itlb ? itlb_update_i : dtlb_update_i;
    other       = pend.itlb ? dtlb_update_i : itlb_update_i;
    served_name = pend.itlb ? "itlb_update_o" : "dtlb_update_o";
    other_name  = pend.itlb ? "dtlb_update_o" : "itlb_update_o";
    check_value("shared_tlb_access_o", 64'(pend.access), 64'(access_i));
    if (!pend.access) begin
      check_value("shared_tlb_hit_o", 64'(1'b0), 64'(hit_i));
      check_value("itlb_update_o.valid", 64'(1'b0), 64'(itlb_update_i.valid));
      check_value("dtlb_update_o.valid", 64'(1'b0), 64'(dtlb_update_i.valid));
    end else begin
      hit_exp = (pend.hit == 2'd2) ? hit_i : pend.hit[0];
      if (pend.hit == 2'd2) count_either(hit_i);
      check_value("itlb_req_o", 64'(pend.itlb), 64'(itlb_req_i));
      check_value("shared_tlb_vaddr_o", 64'(pend.vaddr), 64'(vaddr_i));
      if (pend.hit != 2'd2) check_value("shared_tlb_hit_o", 64'(hit_exp), 64'(hit_i));
      check_value({served_name, ".valid"}, 64'(hit_exp), 64'(served.valid));
      check_value({other_name, ".valid"}, 64'(1'b0), 64'(other.valid));  // silent side
      if (hit_exp) begin
        want       = pend.upd;
        want.valid = 1'b1;
        check_value(served_name, 64'(want), 64'(served));
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      pend = '0;
    end else begin
      check_value("itlb_miss_o", 64'(exp_imiss_i), 64'(itlb_miss_i));
      check_value("dtlb_miss_o", 64'(exp_dmiss_i), 64'(dtlb_miss_i));
      check_result();
      pend = cur;
    end
  end

endmodule

//--- test/stlb_tb.sv
// testbench top for the shared TLB
// clock and reset, stimulus and expected values from the test data file,
// LFSR-chosen idle gaps, watchdog and the closing report

`timescale 1ns/10ps

module stlb_tb;

  localparam string      DataFile = "test/stlb_testdata.txt";
  localparam logic [7:0] GapSeed  = 8'd89;
  localparam logic [7:0] GapTaps  = 8'h8E;

  logic                        clk;
  logic                        rst_n;
  logic                        flush;
  logic                        st_enbl;
  logic                        ld_st_enbl;
  logic [stlb_pkg::ASID_W-1:0] itlb_asid;
  logic [stlb_pkg::ASID_W-1:0] dtlb_asid;
  logic                        itlb_access;
  logic                        itlb_hit;
  logic [stlb_pkg::VLEN-1:0]   itlb_vaddr;
  logic                        dtlb_access;
  logic                        dtlb_hit;
  logic [stlb_pkg::VLEN-1:0]   dtlb_vaddr;
  logic                        walker_miss;
  stlb_pkg::tlb_update_t       refill;
  stlb_pkg::tlb_update_t       itlb_update;
  stlb_pkg::tlb_update_t       dtlb_update;
  logic                        itlb_miss;
  logic                        dtlb_miss;
  logic                        stlb_access;
  logic                        stlb_hit;
  logic [stlb_pkg::VLEN-1:0]   stlb_vaddr;
  logic                        itlb_req;

  // expectations for the checker, valid in the request cycle
  logic                        exp_access;
  logic                        exp_itlb;
  logic [stlb_pkg::VLEN-1:0]   exp_vaddr;
  logic                        exp_imiss;
  logic                        exp_dmiss;
  logic [1:0]                  exp_hit;
  stlb_pkg::tlb_update_t       exp_upd;

  int                          value_errs;
  int                          other_errs;
  int                          stim_errs;
  int                          n_lines;
  logic                        lines_counted;
  logic [7:0]                  gap_lfsr;

  stlb_top #(.Ways(2), .Depth(64)) u_stlb_top (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush),
    .s_st_enbl_i(st_enbl), .s_ld_st_enbl_i(ld_st_enbl),
    .itlb_asid_i(itlb_asid), .dtlb_asid_i(dtlb_asid),
    .itlb_access_i(itlb_access), .itlb_hit_i(itlb_hit), .itlb_vaddr_i(itlb_vaddr),
    .dtlb_access_i(dtlb_access), .dtlb_hit_i(dtlb_hit), .dtlb_vaddr_i(dtlb_vaddr),
    .shared_tlb_miss_i(walker_miss), .shared_tlb_update_i(refill),
    .itlb_update_o(itlb_update), .dtlb_update_o(dtlb_update),
    .itlb_miss_o(itlb_miss), .dtlb_miss_o(dtlb_miss),
    .shared_tlb_access_o(stlb_access), .shared_tlb_hit_o(stlb_hit),
    .shared_tlb_vaddr_o(stlb_vaddr), .itlb_req_o(itlb_req)
  );

  stlb_checker u_checker (
    .clk_i(clk), .rst_ni(rst_n),
    .exp_access_i(exp_access), .exp_itlb_i(exp_itlb), .exp_vaddr_i(exp_vaddr),
    .exp_imiss_i(exp_imiss), .exp_dmiss_i(exp_dmiss), .exp_hit_i(exp_hit),
    .exp_upd_i(exp_upd),
    .itlb_miss_i(itlb_miss), .dtlb_miss_i(dtlb_miss), .access_i(stlb_access),
    .hit_i(stlb_hit), .itlb_req_i(itlb_req), .vaddr_i(stlb_vaddr),
    .itlb_update_i(itlb_update), .dtlb_update_i(dtlb_update),
    .value_errs_o(value_errs), .other_errs_o(other_errs)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic next_rand_bit();
    gap_lfsr = {1'b0, gap_lfsr[7:1]} ^ (gap_lfsr[0] ? GapTaps : 8'h00);
    return gap_lfsr[0];
  endfunction

  task automatic drive_idle();
    flush       = 1'b0;
    st_enbl     = 1'b1;
    ld_st_enbl  = 1'b1;
    itlb_asid   = '0;
    dtlb_asid   = '0;
    itlb_access = 1'b0;
    itlb_hit    = 1'b0;
    itlb_vaddr  = '0;
    dtlb_access = 1'b0;
    dtlb_hit    = 1'b0;
    dtlb_vaddr  = '0;
    walker_miss = 1'b0;
    refill      = '0;
    exp_access  = 1'b0;
    exp_itlb    = 1'b0;
    exp_vaddr   = '0;
    exp_imiss   = 1'b0;
    exp_dmiss   = 1'b0;
    exp_hit     = 2'd0;
    exp_upd     = '0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    drive_idle();
  endtask

  task automatic idle_gap();
    logic [1:0] gap;
    gap[0] = next_rand_bit();
    gap[1] = next_rand_bit();
    repeat (gap) next_cycle();
  endtask

  task automatic do_refill(input logic [19:0] r_vpn, input logic [8:0] r_asid,
                           input logic r_4m, input logic [31:0] r_pte);
    next_cycle();
    refill = '{valid: 1'b1, vpn: r_vpn, is_4m: r_4m, asid: r_asid, content: r_pte};
  endtask

  task automatic do_lookup(input logic [7:0] side, input logic [31:0] iva,
                           input logic [31:0] dva, input logic [8:0] asid,
                           input logic en, input logic miss, input logic [1:0] hit,
                           input logic is_4m, input logic [31:0] pte);
    logic        on_itlb;
    logic        on_dtlb;
    logic [31:0] va;
    on_itlb = (side == "I") || (side == "B");
    on_dtlb = (side == "D") || (side == "B");
    va      = (side == "I") ? iva : dva;  // DTLB wins a tie
    next_cycle();
    itlb_access = on_itlb;
    itlb_vaddr  = iva;
    itlb_asid   = asid;
    dtlb_access = on_dtlb;
    dtlb_vaddr  = dva;
    dtlb_asid   = asid;
    if (on_itlb) st_enbl = en;
    if (on_dtlb) ld_st_enbl = en;
    walker_miss = miss;
    exp_access  = en;
    exp_itlb    = (side == "I");
    exp_vaddr   = va;
    exp_imiss   = en & (side == "I") & miss;
    exp_dmiss   = en & on_dtlb & miss;
    exp_hit     = hit;
    exp_upd     = '{valid: (hit == 2'd1), vpn: va[31:12], is_4m: is_4m, asid: asid,
                    content: pte};
  endtask

  task automatic field_count(input logic [7:0] op, input int got, input int want);
    if (got != want) begin
      stim_errs++;
      $display("test data line %s has %0d fields instead of %0d", op, got, want);
    end
  endtask

  task automatic run_op(input int fd, input logic [7:0] op);
    int               n;
    logic [8*128-1:0] rest;
    logic [7:0]       side;
    logic [19:0]      vpn;
    logic [31:0]      iva;
    logic [31:0]      dva;
    logic [8:0]       asid;
    logic             en;
    logic             miss;
    logic [1:0]       hit;
    logic             is_4m;
    logic [31:0]      pte;
    case (op)
      "#": n = $fgets(rest, fd);  // comment line
      "R": begin
        n = $fscanf(fd, "%h %h %h %h", vpn, asid, is_4m, pte);
        field_count(op, n, 4);
        do_refill(vpn, asid, is_4m, pte);
        idle_gap();
      end
      "L": begin
        n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", side, iva, dva, asid, en, miss, hit,
                    is_4m, pte);
        field_count(op, n, 9);
        do_lookup(side, iva, dva, asid, en, miss, hit, is_4m, pte);
        idle_gap();
      end
      "F": begin
        next_cycle();
        flush = 1'b1;
        idle_gap();
      end
      "I": begin
        next_cycle();
        idle_gap();
      end
      default: begin
        stim_errs++;
        $display("unknown operation %s in test data", op);
      end
    endcase
  endtask

  task automatic count_lines();
    int               fd;
    int               n;
    logic [8*128-1:0] text_line;
    n_lines = 0;
    fd = $fopen(DataFile, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(text_line, fd);
        if (n > 0) n_lines++;
      end
      $fclose(fd);
    end
    lines_counted = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin
    int         fd;
    logic [7:0] op;
    stim_errs     = 0;
    lines_counted = 1'b0;
    gap_lfsr      = GapSeed;
    rst_n         = 1'b0;
    drive_idle();
    count_lines();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen(DataFile, "r");
    if (fd == 0) begin
      stim_errs++;
      $display("cannot open %s for reading", DataFile);
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        run_op(fd, op);
      end
      $fclose(fd);
    end
    repeat (3) next_cycle();  // last result reaches the checker
    $display("errors: %0d wrong values, %0d other, %0d in stimulus",
             value_errs, other_errs, stim_errs);
    if (value_errs + other_errs + stim_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    wait (lines_counted);
    repeat (20 * n_lines + 10) @(posedge clk);
    $display("watchdog expired, stimulus still running after %0d cycles", 20 * n_lines + 10);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- project.f
src/stlb_pkg.sv
src/stlb_way_ram.sv
src/stlb_lookup_req.sv
src/stlb_refill_ctrl.sv
src/stlb_tag_compare.sv
src/stlb_update_route.sv
src/stlb_top.sv
test/stlb_checker.sv
test/stlb_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the shared TLB testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module stlb_tb -f project.f -o stlb_sim

./obj_dir/stlb_sim > sim.log
cat sim.log

if grep -qx "All tests passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported errors, see sim.log"
  exit 1
fi

//--- test/stlb_testdata.txt
# R vpn asid is_4m pte | F flush | I idle
# L side(I D B) itlb_vaddr dtlb_vaddr asid enable walker_miss hit(0 1 2=either) is_4m pte
# fill and hit
R 12345 001 0 0ABCD0CF
L I 12345000 00000000 001 1 1 1 0 0ABCD0CF
L D 00000000 12345ABC 001 1 0 1 0 0ABCD0CF
L D 00000000 54321000 001 1 1 0 0 00000000
# asid and global
L I 12345000 00000000 002 1 0 0 0 00000000
R 2A0C7 003 0 01111021
L D 00000000 2A0C7000 0FF 1 0 1 0 01111021
# superpage
R 40009 004 1 00AB00CF
L I 401C9000 00000000 004 1 0 1 1 00AB00CF
R 8000A 004 0 00CD00CF
L D 00000000 801CA000 004 1 1 0 0 00000000
# arbitration and enables
L B 12345000 2A0C7000 005 1 1 1 0 01111021
L I 12345000 00000000 001 0 1 0 0 00000000
L D 00000000 12345000 001 0 1 0 0 00000000
L B 12345000 54321000 001 0 1 0 0 00000000
I
# replacement in set 15
R 00015 006 0 00015001
R 00055 006 0 00055001
R 00095 006 0 00095001
L D 00000000 00095000 006 1 0 1 0 00095001
L D 00000000 00015000 006 1 0 2 0 00015001
L I 00055000 00000000 006 1 0 2 0 00055001
# flush
F
L I 12345000 00000000 001 1 1 0 0 00000000
L D 00000000 2A0C7000 005 1 1 0 0 00000000
L D 00000000 00095000 006 1 0 0 0 00000000
L I 401C9000 00000000 004 1 0 0 0 00000000
R 12345 001 0 0ABCD0CF
L D 00000000 12345000 001 1 0 1 0 0ABCD0CF
